//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = harness_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- files.f
logic/harness_pkg.sv
logic/harness_fifo.sv
logic/io_router.sv
logic/host_regs.sv
logic/dram_model.sv
logic/harness_top.sv
tests/harness_tb.sv

//--- logic/dram_model.sv
/*
  Word-addressed DRAM stand-in. The array is written or sampled on the
  dispatch cycle and the answer travels down a fixed-latency pipeline,
  so several requests can be outstanding at once.
*/

`timescale 1ns/1ps
`default_nettype none

module dram_model (
  input  wire logic                              clk_i,
  input  wire logic                              rst_n_i,
  input  wire logic                              req_v_i,
  input  wire logic                              req_write_i,
  input  wire logic [harness_pkg::ADDR_W-1:0]    req_addr_i,
  input  wire logic [harness_pkg::DATA_W-1:0]    req_data_i,
  output logic                                   rsp_v_o,
  output logic [harness_pkg::DATA_W-1:0]         rsp_data_o
);

  logic [harness_pkg::DATA_W-1:0]       mem [2**harness_pkg::DRAM_AW];
  logic [harness_pkg::DRAM_AW-1:0]      idx;
  logic [harness_pkg::DRAM_LATENCY-1:0] v_q;
  logic [harness_pkg::DATA_W-1:0]       d_q [harness_pkg::DRAM_LATENCY];

  assign idx = req_addr_i[harness_pkg::DRAM_AW-1:0];

  always_ff @(posedge clk_i)
  begin
    if (req_v_i && req_write_i)
    begin
      mem[idx] <= req_data_i;
    end
  end

  // Stage 0 samples the array; writes answer zero
  always_ff @(posedge clk_i)
  begin
    d_q[0] <= req_write_i ? '0 : mem[idx];
    for (int i = 1; i < harness_pkg::DRAM_LATENCY; i++)
    begin
      d_q[i] <= d_q[i-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      v_q <= '0;
    end
    else
    begin
      v_q[0] <= req_v_i;
      for (int i = 1; i < harness_pkg::DRAM_LATENCY; i++)
      begin
        v_q[i] <= v_q[i-1];
      end
    end
  end

  assign rsp_v_o    = v_q[harness_pkg::DRAM_LATENCY-1];
  assign rsp_data_o = d_q[harness_pkg::DRAM_LATENCY-1];

endmodule

`default_nettype wire

//--- logic/harness_fifo.sv
/*
  Small ready/valid queue over a circular buffer. The payload type is a
  parameter so the same queue carries commands and responses. Occupancy
  is exported for credit accounting.
*/

`timescale 1ns/1ps
`default_nettype none

module harness_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  wire logic                       clk_i,
  input  wire logic                       rst_n_i,
  input  wire logic                       push_v_i,
  input  wire payload_t                   push_data_i,
  output logic                            push_ready_o,
  output logic                            pop_v_o,
  output payload_t                        pop_data_o,
  input  wire logic                       pop_ready_i,
  output logic [$clog2(DEPTH+1)-1:0]      count_o
);

  payload_t                     mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]   count_q;
  logic                         do_push;
  logic                         do_pop;

  assign push_ready_o = (count_q != DEPTH);
  assign pop_v_o      = (count_q != '0);
  assign pop_data_o   = mem[rd_ptr_q];
  assign count_o      = count_q;

  assign do_push = push_v_i && push_ready_o;
  assign do_pop  = pop_v_o && pop_ready_i;

  always_ff @(posedge clk_i)
  begin
    if (do_push)
    begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/harness_pkg.sv
/*
  Shared widths, address map, latencies and payload types for the
  memory-side harness fabric. Modules reach these by scoped names.
*/

`default_nettype none

package harness_pkg;

  localparam int ADDR_W       = 16;
  localparam int DATA_W       = 32;

  // Address bit 15 set selects the host window
  localparam int HOST_SEL_BIT = 15;
  localparam int DRAM_AW      = 8;

  localparam int DRAM_LATENCY = 3;
  localparam int HOST_LATENCY = 1;

  localparam int QUEUE_DEPTH  = 4;
  localparam int CNT_W        = $clog2(QUEUE_DEPTH + 1);

  localparam int TRACE_W         = 4;
  localparam int HOST_FINISH_OFS = 0;
  localparam int HOST_TRACE_OFS  = 1;

  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } cmd_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
  } rsp_t;

endpackage

`default_nettype wire

//--- logic/harness_top.sv
/*
  Top of the harness fabric. Commands enter a queue, the router sends them
  to the host registers or the DRAM model, and responses leave through a
  second queue in command order.
*/

`timescale 1ns/1ps
`default_nettype none

module harness_top (
  input  wire logic                              clk_i,
  input  wire logic                              rst_n_i,
  input  wire logic                              cmd_v_i,
  input  wire logic                              cmd_write_i,
  input  wire logic [harness_pkg::ADDR_W-1:0]    cmd_addr_i,
  input  wire logic [harness_pkg::DATA_W-1:0]    cmd_data_i,
  output logic                                   cmd_ready_o,
  output logic                                   rsp_v_o,
  output logic [harness_pkg::DATA_W-1:0]         rsp_data_o,
  input  wire logic                              rsp_ready_i,
  output logic                                   finish_o,
  output logic [harness_pkg::TRACE_W-1:0]        trace_en_o
);

  harness_pkg::cmd_t              cmd_in;
  harness_pkg::cmd_t              cmd_head;
  logic                           cmd_head_v;
  logic                           cmd_head_ready;
  harness_pkg::rsp_t              rsp_push;
  logic                           rsp_push_v;
  harness_pkg::rsp_t              rsp_head;
  logic [harness_pkg::CNT_W-1:0]  rsp_count;
  logic                           rsp_pop;
  logic                           host_v;
  logic                           dram_v;
  logic                           req_write;
  logic [harness_pkg::ADDR_W-1:0] req_addr;
  logic [harness_pkg::DATA_W-1:0] req_data;
  logic                           host_rsp_v;
  logic [harness_pkg::DATA_W-1:0] host_rsp_data;
  logic                           dram_rsp_v;
  logic [harness_pkg::DATA_W-1:0] dram_rsp_data;

  assign cmd_in.write = cmd_write_i;
  assign cmd_in.addr  = cmd_addr_i;
  assign cmd_in.data  = cmd_data_i;
  assign rsp_data_o   = rsp_head.data;
  assign rsp_pop      = rsp_v_o && rsp_ready_i;

  harness_fifo #(.payload_t(harness_pkg::cmd_t), .DEPTH(harness_pkg::QUEUE_DEPTH)) u_cmd_q (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .push_v_i(cmd_v_i), .push_data_i(cmd_in), .push_ready_o(cmd_ready_o),
    .pop_v_o(cmd_head_v), .pop_data_o(cmd_head), .pop_ready_i(cmd_head_ready),
    .count_o()
  );

  io_router u_router (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_v_i(cmd_head_v), .cmd_i(cmd_head), .cmd_ready_o(cmd_head_ready),
    .host_v_o(host_v), .dram_v_o(dram_v),
    .req_write_o(req_write), .req_addr_o(req_addr), .req_data_o(req_data),
    .host_rsp_v_i(host_rsp_v), .host_rsp_data_i(host_rsp_data),
    .dram_rsp_v_i(dram_rsp_v), .dram_rsp_data_i(dram_rsp_data),
    .rsp_count_i(rsp_count), .rsp_pop_i(rsp_pop),
    .rsp_v_o(rsp_push_v), .rsp_o(rsp_push)
  );

  host_regs u_host (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .req_v_i(host_v), .req_write_i(req_write), .req_addr_i(req_addr), .req_data_i(req_data),
    .rsp_v_o(host_rsp_v), .rsp_data_o(host_rsp_data),
    .finish_o(finish_o), .trace_en_o(trace_en_o)
  );

  dram_model u_dram (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .req_v_i(dram_v), .req_write_i(req_write), .req_addr_i(req_addr), .req_data_i(req_data),
    .rsp_v_o(dram_rsp_v), .rsp_data_o(dram_rsp_data)
  );

  // Credits guarantee room, so push_ready is not needed
  harness_fifo #(.payload_t(harness_pkg::rsp_t), .DEPTH(harness_pkg::QUEUE_DEPTH)) u_rsp_q (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .push_v_i(rsp_push_v), .push_data_i(rsp_push), .push_ready_o(),
    .pop_v_o(rsp_v_o), .pop_data_o(rsp_head), .pop_ready_i(rsp_ready_i),
    .count_o(rsp_count)
  );

endmodule

`default_nettype wire

//--- logic/host_regs.sv
/*
  Host register window. Holds the sticky finish flag and the trace enables
  and answers every request after the host latency. Writes answer zero.
*/

`timescale 1ns/1ps
`default_nettype none

module host_regs (
  input  wire logic                              clk_i,
  input  wire logic                              rst_n_i,
  input  wire logic                              req_v_i,
  input  wire logic                              req_write_i,
  input  wire logic [harness_pkg::ADDR_W-1:0]    req_addr_i,
  input  wire logic [harness_pkg::DATA_W-1:0]    req_data_i,
  output logic                                   rsp_v_o,
  output logic [harness_pkg::DATA_W-1:0]         rsp_data_o,
  output logic                                   finish_o,
  output logic [harness_pkg::TRACE_W-1:0]        trace_en_o
);

  logic [harness_pkg::HOST_SEL_BIT-1:0] ofs;
  logic [harness_pkg::DATA_W-1:0]       rd_data;
  logic [harness_pkg::HOST_LATENCY-1:0] v_q;
  logic [harness_pkg::DATA_W-1:0]       d_q [harness_pkg::HOST_LATENCY];

  assign ofs = req_addr_i[harness_pkg::HOST_SEL_BIT-1:0];

  always_comb
  begin
    rd_data = '0;
    if (ofs == harness_pkg::HOST_FINISH_OFS)
    begin
      rd_data[0] = finish_o;
    end
    else if (ofs == harness_pkg::HOST_TRACE_OFS)
    begin
      rd_data[harness_pkg::TRACE_W-1:0] = trace_en_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      finish_o   <= 1'b0;
      trace_en_o <= '0;
      v_q        <= '0;
    end
    else
    begin
      if (req_v_i && req_write_i)
      begin
        // Finish only ever sets
        if (ofs == harness_pkg::HOST_FINISH_OFS && req_data_i[0])
        begin
          finish_o <= 1'b1;
        end
        if (ofs == harness_pkg::HOST_TRACE_OFS)
        begin
          trace_en_o <= req_data_i[harness_pkg::TRACE_W-1:0];
        end
      end
      v_q[0] <= req_v_i;
      for (int i = 1; i < harness_pkg::HOST_LATENCY; i++)
      begin
        v_q[i] <= v_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i)
  begin
    d_q[0] <= req_write_i ? '0 : rd_data;
    for (int i = 1; i < harness_pkg::HOST_LATENCY; i++)
    begin
      d_q[i] <= d_q[i-1];
    end
  end

  assign rsp_v_o    = v_q[harness_pkg::HOST_LATENCY-1];
  assign rsp_data_o = d_q[harness_pkg::HOST_LATENCY-1];

endmodule

`default_nettype wire

//--- logic/io_router.sv
/*
  Routes queued commands to the host block or the DRAM model by address.
  Dispatch is registered. A command is taken only while credits remain and
  its target matches the group in flight, so responses return in order.
*/

`timescale 1ns/1ps
`default_nettype none

module io_router (
  input  wire logic                              clk_i,
  input  wire logic                              rst_n_i,
  input  wire logic                              cmd_v_i,
  input  wire harness_pkg::cmd_t                 cmd_i,
  output logic                                   cmd_ready_o,
  output logic                                   host_v_o,
  output logic                                   dram_v_o,
  output logic                                   req_write_o,
  output logic [harness_pkg::ADDR_W-1:0]         req_addr_o,
  output logic [harness_pkg::DATA_W-1:0]         req_data_o,
  input  wire logic                              host_rsp_v_i,
  input  wire logic [harness_pkg::DATA_W-1:0]    host_rsp_data_i,
  input  wire logic                              dram_rsp_v_i,
  input  wire logic [harness_pkg::DATA_W-1:0]    dram_rsp_data_i,
  input  wire logic [harness_pkg::CNT_W-1:0]     rsp_count_i,
  input  wire logic                              rsp_pop_i,
  output logic                                   rsp_v_o,
  output harness_pkg::rsp_t                      rsp_o
);

  logic [harness_pkg::CNT_W-1:0] inflight_q;
  logic [harness_pkg::CNT_W:0]   used;
  logic                          grp_host_q;
  logic                          cmd_host;
  logic                          accept;

  assign cmd_host = cmd_i.addr[harness_pkg::HOST_SEL_BIT];

  // Slots already promised to the response queue
  assign used = inflight_q + rsp_count_i - rsp_pop_i;

  assign cmd_ready_o = (used < harness_pkg::QUEUE_DEPTH)
                    && ((inflight_q == '0) || (grp_host_q == cmd_host));
  assign accept = cmd_v_i && cmd_ready_o;

  // Groups never overlap, so at most one strobe is high
  assign rsp_v_o    = host_rsp_v_i || dram_rsp_v_i;
  assign rsp_o.data = host_rsp_v_i ? host_rsp_data_i : dram_rsp_data_i;

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      inflight_q <= '0;
      grp_host_q <= 1'b0;
      host_v_o   <= 1'b0;
      dram_v_o   <= 1'b0;
    end
    else
    begin
      case ({accept, rsp_v_o})
        2'b10:   inflight_q <= inflight_q + 1'b1;
        2'b01:   inflight_q <= inflight_q - 1'b1;
        default: inflight_q <= inflight_q;
      endcase
      if (accept)
      begin
        grp_host_q <= cmd_host;
      end
      host_v_o <= accept && cmd_host;
      dram_v_o <= accept && !cmd_host;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
    begin
      req_write_o <= cmd_i.write;
      req_addr_o  <= cmd_i.addr;
      req_data_o  <= cmd_i.data;
    end
  end

endmodule

`default_nettype wire

//--- tests/harness_tb.sv
/*
  Testbench for harness_top. Replays the command vectors, then adds random
  DRAM traffic and a back-pressure phase, and checks every response in order.
  Run from the project root so the vector path resolves.
*/

`timescale 1ns/1ps
`default_nettype none

module harness_tb;

  localparam int SEND_TIMEOUT  = 60;
  localparam int DRAIN_TIMEOUT = 200;

  logic        clk_i;
  logic        rst_n_i;
  logic        cmd_v_i;
  logic        cmd_write_i;
  logic [15:0] cmd_addr_i;
  logic [31:0] cmd_data_i;
  wire logic   cmd_ready_o;
  wire logic   rsp_v_o;
  wire logic [31:0] rsp_data_o;
  logic        rsp_ready_i;
  wire logic   finish_o;
  wire logic [3:0] trace_en_o;

  logic [31:0] exp_q [$];
  logic        hold_ready;
  logic [31:0] cmd_state;
  logic [31:0] rdy_state;

  harness_top uut (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .cmd_v_i(cmd_v_i), .cmd_write_i(cmd_write_i), .cmd_addr_i(cmd_addr_i),
    .cmd_data_i(cmd_data_i), .cmd_ready_o(cmd_ready_o),
    .rsp_v_o(rsp_v_o), .rsp_data_o(rsp_data_o), .rsp_ready_i(rsp_ready_i),
    .finish_o(finish_o), .trace_en_o(trace_en_o)
  );

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1);
    end
  endtask

  // Called at posedge + 1; returns there after the transfer edge
  task automatic send_cmd(input logic wr, input logic [15:0] addr, input logic [31:0] data,
                          input logic [31:0] expected);
    int waited;
    waited = 0;
    cmd_v_i     = 1'b1;
    cmd_write_i = wr;
    cmd_addr_i  = addr;
    cmd_data_i  = data;
    @(negedge clk_i);
    while (!cmd_ready_o)
    begin
      if (waited >= SEND_TIMEOUT)
      begin
        fail_run("command was not accepted before the timeout");
      end
      waited++;
      @(negedge clk_i);
    end
    exp_q.push_back(expected);
    @(posedge clk_i);
    #1;
    cmd_v_i = 1'b0;
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0)
    begin
      if (waited >= DRAIN_TIMEOUT)
      begin
        fail_run("expected responses still outstanding at the timeout");
      end
      waited++;
      @(posedge clk_i);
      #1;
    end
  endtask

  // Ready toggles from its own stream unless held low
  always @(posedge clk_i)
  begin
    #1;
    rdy_state   = xorshift(rdy_state);
    rsp_ready_i = !hold_ready && (rdy_state[1:0] != 2'b00);
  end

  // Inputs only move at posedge + 1, so negedge sees the coming transfer
  always @(negedge clk_i)
  begin
    if (rst_n_i && rsp_v_o && rsp_ready_i)
    begin
      if (exp_q.size() == 0)
      begin
        fail_run("a response arrived when none was expected");
      end
      check("rsp_data_o", rsp_data_o, exp_q.pop_front());
    end
  end

  initial
  begin
    int          fd;
    int          rc;
    int          vec_count;
    int          held;
    string       line;
    logic [31:0] v_wr;
    logic [31:0] v_addr;
    logic [31:0] v_data;
    logic [31:0] v_exp;
    logic        finish_exp;
    logic [3:0]  trace_exp;
    logic [31:0] ref_mem [16];
    logic [15:0] ref_ok;
    logic [3:0]  slot;
    logic        wr;
    clk_i = 1'b0;
    rst_n_i = 1'b0;
    cmd_v_i = 1'b0;
    cmd_write_i = 1'b0;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    rsp_ready_i = 1'b0;
    hold_ready = 1'b0;
    vec_count = 0;
    finish_exp = 1'b0;
    trace_exp = '0;
    ref_ok = '0;
    cmd_state = 32'd11;
    rdy_state = 32'd11 ^ 32'h9e3779b9;
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;
    check("finish_o", {31'b0, finish_o}, 32'd0);
    check("trace_en_o", {28'b0, trace_en_o}, 32'd0);
    check("rsp_v_o", {31'b0, rsp_v_o}, 32'd0);
    check("cmd_ready_o", {31'b0, cmd_ready_o}, 32'd1);

    fd = $fopen("tests/harness_vectors.txt", "r");
    if (fd == 0)
    begin
      fail_run("could not open the vector file tests/harness_vectors.txt");
    end
    while (!$feof(fd))
    begin
      line = "";
      rc = $fgets(line, fd);
      if (line.len() == 0 || line[0] == "#")
      begin
        continue;
      end
      rc = $sscanf(line, "%h %h %h %h", v_wr, v_addr, v_data, v_exp);
      if (rc != 4)
      begin
        continue;
      end
      // Host register model for the end-of-file checks
      if (v_addr[15] && v_wr[0])
      begin
        if (v_addr[14:0] == 15'd0 && v_data[0])
        begin
          finish_exp = 1'b1;
        end
        if (v_addr[14:0] == 15'd1)
        begin
          trace_exp = v_data[3:0];
        end
      end
      send_cmd(v_wr[0], v_addr[15:0], v_data, v_exp);
      vec_count++;
    end
    $fclose(fd);
    if (vec_count == 0)
    begin
      fail_run("the vector file held no commands");
    end
    wait_drained();
    check("finish_o", {31'b0, finish_o}, {31'b0, finish_exp});
    check("trace_en_o", {28'b0, trace_en_o}, {28'b0, trace_exp});

    // Random DRAM traffic over 16 words at 0x40
    for (int i = 0; i < 40; i++)
    begin
      cmd_state = xorshift(cmd_state);
      slot = cmd_state[3:0];
      wr = cmd_state[4] || !ref_ok[slot];
      cmd_state = xorshift(cmd_state);
      if (wr)
      begin
        ref_mem[slot] = cmd_state;
        ref_ok[slot] = 1'b1;
        send_cmd(1'b1, 16'h0040 + 16'(slot), cmd_state, 32'd0);
      end
      else
      begin
        send_cmd(1'b0, 16'h0040 + 16'(slot), cmd_state, ref_mem[slot]);
      end
    end
    wait_drained();

    // Back-pressure: eight commands fill the response and command queues
    hold_ready = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
      send_cmd(1'b1, 16'h0020 + 16'(i), 32'h5a000000 + i, 32'd0);
    end
    for (int i = 0; i < 4; i++)
    begin
      send_cmd(1'b0, 16'h0020 + 16'(i), 32'd0, 32'h5a000000 + i);
    end
    held = 0;
    while (cmd_ready_o)
    begin
      if (held >= 40)
      begin
        fail_run("cmd_ready_o never dropped while responses were held back");
      end
      held++;
      @(posedge clk_i);
      #1;
    end
    // Held responses stay waiting at the queue head
    repeat (30) @(posedge clk_i);
    #1;
    check("rsp_v_o", {31'b0, rsp_v_o}, 32'd1);
    check("cmd_ready_o", {31'b0, cmd_ready_o}, 32'd0);
    hold_ready = 1'b0;
    wait_drained();
    repeat (10) @(posedge clk_i);
    #1;
    check("rsp_v_o", {31'b0, rsp_v_o}, 32'd0);
    check("finish_o", {31'b0, finish_o}, 32'd1);
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/harness_vectors.txt
# write addr data expected_rsp, all hex, one command per line
# Host window is addr bit 15 with finish at offset 0 and trace at offset 1
1 0010 deadbeef 00000000
1 0011 12345678 00000000
1 0012 cafef00d 00000000
0 0010 00000000 deadbeef
0 0011 00000000 12345678
0 0012 00000000 cafef00d
1 0010 0badf00d 00000000
0 0010 00000000 0badf00d
1 8001 0000000a 00000000
0 8001 00000000 0000000a
0 8000 00000000 00000000
1 8000 00000003 00000000
0 8000 00000000 00000001
0 8001 00000000 0000000a
0 0011 00000000 12345678
0 8000 00000000 00000001
0 0012 00000000 cafef00d
1 8001 00000005 00000000
0 0010 00000000 0badf00d
0 8001 00000000 00000005
1 8000 00000000 00000000
0 8000 00000000 00000001
1 8002 ffffffff 00000000
0 8002 00000000 00000000
